// File: source/axi_rd_pkg.sv
package axi_rd_pkg;

  // **************************************************
  // Bus widths and AXI constants
  // **************************************************

  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 32;
  localparam int ID_W     = 4;
  localparam int LEN_W    = 8;   // AXI4 burst length field
  localparam int ADDR_LSB = 2;   // Byte offset bits of one data word
  localparam int WDOG_W   = 9;   // Top bit set marks a stall

  localparam logic [1:0] BURST_INCR = 2'd1;
  localparam logic [1:0] BURST_WRAP = 2'd2;

  localparam int RESP_ERR_BIT = 1; // SLVERR and DECERR both set bit 1

  // **************************************************
  // Opcodes and state codes
  // **************************************************

  // User opcode, every other code is ignored
  typedef enum logic [2:0] {
    RD_INCR = 3'b000,
    RD_WRAP = 3'b001
  } rd_op_e;

  typedef enum logic [2:0] {
    IDLE,
    ADDR,   // AR pending
    DATA,   // R beats flowing
    DRAIN,  // Last beat in, user still reading
    ABORT   // Watchdog fired
  } rd_state_e;

  // Where a transaction ended
  typedef enum logic [1:0] {
    STG_OK      = 2'b00,
    STG_ADDR_TO = 2'b01,
    STG_DATA_TO = 2'b10
  } rd_stage_e;

  // **************************************************
  // Payload structs
  // **************************************************

  typedef struct packed {
    rd_op_e              op;
    logic [LEN_W-1:0]    blen;  // Beats minus one
    logic [ADDR_W-1:0]   addr;
    logic [2:0]          size;
  } rd_cmd_t;

  typedef struct packed {
    logic [ID_W-1:0]     id;
    logic [ADDR_W-1:0]   addr;
    logic [LEN_W-1:0]    len;
    logic [2:0]          size;
    logic [1:0]          burst;
  } axi_ar_t;

  typedef struct packed {
    logic [ID_W-1:0]     id;
    logic [DATA_W-1:0]   data;
    logic [1:0]          resp;
    logic                last;
  } axi_r_t;

  typedef struct packed {
    logic [LEN_W-1:0]    beat_cnt;
    rd_stage_e           stage;
    logic                id_err;
    logic                resp_err;
  } rd_sts_t;

endpackage

// File: source/axi_rd_fsm.sv
`timescale 1ns/1ps

module axi_rd_fsm (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  cmd_en,
  input  axi_rd_pkg::rd_op_e    cmd_op,
  input  logic                  axi_arready,
  input  logic                  last_in,
  input  logic                  drained,
  input  logic                  timeout,
  output logic                  cmd_ack,
  output logic                  cmd_take,
  output logic                  axi_arvalid,
  output axi_rd_pkg::rd_state_e state
);
  import axi_rd_pkg::*;

  rd_state_e state_nxt;
  logic      rd_op_ok;

  // **************************************************
  // Command acceptance
  // **************************************************

  // Write and reserved codes never get an ack
  assign rd_op_ok = (cmd_op == RD_INCR) || (cmd_op == RD_WRAP);

  assign cmd_take = cmd_en && rd_op_ok && (state == IDLE);
  assign cmd_ack  = cmd_take;  // Same cycle as capture

  // **************************************************
  // Transaction state
  // **************************************************

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (cmd_take) begin
          state_nxt = ADDR;
        end
      end
      ADDR: begin
        if (timeout) begin
          state_nxt = ABORT;
        end else if (axi_arvalid && axi_arready) begin
          state_nxt = DATA;
        end
      end
      DATA: begin
        if (timeout) begin
          state_nxt = ABORT;
        end else if (last_in) begin
          state_nxt = DRAIN;
        end
      end
      DRAIN: begin
        if (drained) begin
          state_nxt = IDLE;
        end else if (timeout) begin
          state_nxt = ABORT;
        end
      end
      ABORT: begin
        // Leave once the terminating word is taken
        if (drained) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state       <= IDLE;
      axi_arvalid <= 1'b0;
    end else begin
      state       <= state_nxt;
      axi_arvalid <= (state_nxt == ADDR);  // High through ADDR only
    end
  end

  // **************************************************
  // Protocol checks
  // **************************************************

  // AR request is only withdrawn by the watchdog
  a_arvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    axi_arvalid && !axi_arready && !timeout |=> axi_arvalid);

  a_ack_idle: assert property (@(posedge aclk) disable iff (!aresetn)
    cmd_ack |-> (state == IDLE) ##1 (state == ADDR && axi_arvalid));

endmodule

// File: source/axi_rd_wdog.sv
`timescale 1ns/1ps

module axi_rd_wdog (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  axi_rd_pkg::rd_state_e state,
  input  logic                  axi_arvalid,
  input  logic                  axi_arready,
  input  logic                  progress,
  input  logic                  wdog_mask,
  output logic                  timeout
);
  import axi_rd_pkg::*;

  logic [WDOG_W-1:0] cnt;
  logic              active;
  logic              clr;
  logic              inc;

  // ABORT is excluded so a stall fires only once
  assign active = (state == ADDR) || (state == DATA) || (state == DRAIN);
  assign clr    = (state == IDLE) || (axi_arvalid && axi_arready) || progress;
  assign inc    = active && !wdog_mask && !cnt[WDOG_W-1];  // Saturates at top bit

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      cnt     <= '0;
      timeout <= 1'b0;
    end else begin
      timeout <= 1'b0;
      if (clr) begin
        cnt <= '0;
      end else if (inc) begin
        cnt     <= cnt + 1'b1;
        timeout <= &cnt[WDOG_W-2:0];  // Pulse as the top bit sets
      end
    end
  end

endmodule

// File: source/axi_rd_cmd.sv
`timescale 1ns/1ps

module axi_rd_cmd (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  axi_rd_pkg::rd_cmd_t   cmd,
  input  logic                  cmd_take,
  input  axi_rd_pkg::rd_state_e state,
  output axi_rd_pkg::axi_ar_t   axi_ar
);
  import axi_rd_pkg::*;

  rd_cmd_t         cmd_q;
  rd_state_e       state_q;
  logic [ID_W-1:0] id_cnt;
  logic [1:0]      burst;

  // **************************************************
  // Command capture
  // **************************************************

  always_ff @(posedge aclk) begin
    if (cmd_take) begin
      cmd_q <= cmd;
    end
  end

  // **************************************************
  // Transaction ID
  // **************************************************

  // Bumped only after a clean finish, an aborted ID is reused
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= IDLE;
      id_cnt  <= '0;
    end else begin
      state_q <= state;
      if (state_q == DRAIN && state == IDLE) begin
        id_cnt <= id_cnt + 1'b1;
      end
    end
  end

  // **************************************************
  // AR payload
  // **************************************************

  assign burst = (cmd_q.op == RD_WRAP) ? BURST_WRAP : BURST_INCR;

  assign axi_ar = '{
    id:    id_cnt,
    addr:  {cmd_q.addr[ADDR_W-1:ADDR_LSB], {ADDR_LSB{1'b0}}},  // Word aligned
    len:   cmd_q.blen,
    size:  cmd_q.size,
    burst: burst
  };

endmodule

// File: source/axi_rd_data.sv
`timescale 1ns/1ps

module axi_rd_data (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  axi_rd_pkg::rd_state_e         state,
  input  axi_rd_pkg::axi_r_t            axi_r,
  input  logic                          axi_rvalid,
  input  logic [axi_rd_pkg::ID_W-1:0]   expect_id,
  input  logic                          rddata_rdy,
  output logic                          axi_rready,
  output logic                          rddata_vld,
  output logic [axi_rd_pkg::DATA_W-1:0] rddata_data,
  output logic                          rddata_cmptd,
  output axi_rd_pkg::rd_sts_t           rddata_sts,
  output logic                          last_in,
  output logic                          drained,
  output logic                          progress
);
  import axi_rd_pkg::*;

  axi_r_t           fifo_q [2];
  logic             wr_ptr;
  logic             rd_ptr;
  logic [1:0]       fill;
  logic             fifo_vld;
  logic             push;
  logic             pop;
  logic             aborting;
  logic [LEN_W-1:0] beat_cnt;
  logic             id_err;
  logic             resp_err;
  rd_stage_e        abort_stg;
  rd_stage_e        sts_stage;

  // **************************************************
  // Two-entry beat buffer
  // **************************************************

  assign aborting   = (state == ABORT);
  assign fifo_vld   = (fill != 2'd0);
  assign axi_rready = (state == DATA) && (fill != 2'd2);
  assign push       = axi_rvalid && axi_rready;
  assign pop        = fifo_vld && rddata_rdy;

  always_ff @(posedge aclk) begin
    if (push) begin
      fifo_q[wr_ptr] <= axi_r;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      fill   <= 2'd0;
    end else if (aborting) begin  // Stale beats are dropped
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      fill   <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // **************************************************
  // User read port
  // **************************************************

  // In ABORT a single zero word closes the transaction
  assign rddata_vld   = fifo_vld || aborting;
  assign rddata_data  = aborting ? '0 : fifo_q[rd_ptr].data;
  assign rddata_cmptd = aborting || (fifo_vld && fifo_q[rd_ptr].last);

  assign last_in  = push && axi_r.last;
  assign drained  = rddata_vld && rddata_rdy && rddata_cmptd;
  assign progress = push || (rddata_vld && rddata_rdy);

  // **************************************************
  // Status collection
  // **************************************************

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      beat_cnt <= '0;
      id_err   <= 1'b0;
      resp_err <= 1'b0;
    end else if (state == ADDR) begin
      beat_cnt <= '0;
      id_err   <= 1'b0;
      resp_err <= 1'b0;
    end else if (push) begin
      beat_cnt <= beat_cnt + 1'b1;
      id_err   <= id_err || (axi_r.id != expect_id);
      resp_err <= resp_err || axi_r.resp[RESP_ERR_BIT];
    end
  end

  // Remembers which phase a later abort would come from
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      abort_stg <= STG_OK;
    end else if (state == ADDR) begin
      abort_stg <= STG_ADDR_TO;
    end else if (state == DATA || state == DRAIN) begin
      abort_stg <= STG_DATA_TO;
    end
  end

  assign sts_stage  = aborting ? abort_stg : STG_OK;
  assign rddata_sts = '{beat_cnt: beat_cnt, stage: sts_stage, id_err: id_err,
                        resp_err: resp_err};

  // Never more than two beats held, pointers agree with the fill level
  a_fill_bound: assert property (@(posedge aclk) disable iff (!aresetn)
    (fill != 2'd3) && ((fill == 2'd1) == (wr_ptr != rd_ptr)));

  a_user_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    rddata_vld && !rddata_rdy |=> aborting || (rddata_vld && $stable(rddata_data)));

endmodule

// File: source/axi_rd_master.sv
`timescale 1ns/1ps

module axi_rd_master (
  input  logic                          aclk,
  input  logic                          aresetn,
  // User command port
  input  logic                          cmd_en,
  input  axi_rd_pkg::rd_cmd_t           cmd,
  input  logic                          wdog_mask,
  output logic                          cmd_ack,
  // AXI AR channel
  output axi_rd_pkg::axi_ar_t           axi_ar,
  output logic                          axi_arvalid,
  input  logic                          axi_arready,
  // AXI R channel
  input  axi_rd_pkg::axi_r_t            axi_r,
  input  logic                          axi_rvalid,
  output logic                          axi_rready,
  // User read port
  output logic                          rddata_vld,
  output logic [axi_rd_pkg::DATA_W-1:0] rddata_data,
  output logic                          rddata_cmptd,
  output axi_rd_pkg::rd_sts_t           rddata_sts,
  input  logic                          rddata_rdy
);
  import axi_rd_pkg::*;

  rd_state_e state;
  logic      cmd_take;
  logic      last_in;
  logic      drained;
  logic      progress;
  logic      timeout;

  axi_rd_fsm i_fsm (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .cmd_en      (cmd_en),
    .cmd_op      (cmd.op),
    .axi_arready (axi_arready),
    .last_in     (last_in),
    .drained     (drained),
    .timeout     (timeout),
    .cmd_ack     (cmd_ack),
    .cmd_take    (cmd_take),
    .axi_arvalid (axi_arvalid),
    .state       (state)
  );

  axi_rd_wdog i_wdog (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .state       (state),
    .axi_arvalid (axi_arvalid),
    .axi_arready (axi_arready),
    .progress    (progress),
    .wdog_mask   (wdog_mask),
    .timeout     (timeout)
  );

  axi_rd_cmd i_cmd (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .cmd      (cmd),
    .cmd_take (cmd_take),
    .state    (state),
    .axi_ar   (axi_ar)
  );

  // R beats are checked against the ID issued on AR
  axi_rd_data i_data (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .state        (state),
    .axi_r        (axi_r),
    .axi_rvalid   (axi_rvalid),
    .expect_id    (axi_ar.id),
    .rddata_rdy   (rddata_rdy),
    .axi_rready   (axi_rready),
    .rddata_vld   (rddata_vld),
    .rddata_data  (rddata_data),
    .rddata_cmptd (rddata_cmptd),
    .rddata_sts   (rddata_sts),
    .last_in      (last_in),
    .drained      (drained),
    .progress     (progress)
  );

endmodule

// File: verif/axi_rd_slave_model.sv
`timescale 1ns/1ps

module axi_rd_slave_model (
  input  logic                         aclk,
  input  logic                         aresetn,
  input  axi_rd_pkg::axi_ar_t          axi_ar,
  input  logic                         axi_arvalid,
  output logic                         axi_arready,
  output axi_rd_pkg::axi_r_t           axi_r,
  output logic                         axi_rvalid,
  input  logic                         axi_rready,
  input  logic [3:0]                   ar_delay,  // Idle cycles before arready
  input  logic                         ar_block,  // Hold off arready entirely
  input  logic                         bad_id,
  input  logic                         err_en,
  input  logic [axi_rd_pkg::LEN_W-1:0] err_beat
);
  import axi_rd_pkg::*;

  axi_ar_t          ar_q;
  logic             rst_n_q   = 1'b0;
  logic             block_q   = 1'b0;
  logic             ar_hs     = 1'b0;
  logic             r_hs      = 1'b0;
  logic             arready_q = 1'b0;
  logic             rvalid_q  = 1'b0;
  axi_r_t           r_q       = '0;
  logic             busy      = 1'b0;
  logic [LEN_W-1:0] beat      = '0;
  logic [3:0]       wait_cnt  = '0;

  assign axi_arready = arready_q;
  assign axi_rvalid  = rvalid_q;
  assign axi_r       = r_q;

  // Handshakes seen at the rising edge
  always @(posedge aclk) begin
    rst_n_q <= aresetn;
    block_q <= ar_block;
    ar_hs   <= axi_arvalid && axi_arready;
    r_hs    <= axi_rvalid && axi_rready;
    if (axi_arvalid && axi_arready) begin
      ar_q <= axi_ar;
    end
  end

  // **************************************************
  // Outputs change on the falling edge
  // **************************************************

  always @(negedge aclk) begin
    if (!rst_n_q) begin
      arready_q = 1'b0;
      rvalid_q  = 1'b0;
      busy      = 1'b0;
      beat      = '0;
      wait_cnt  = '0;
    end else begin
      if (ar_hs) begin
        arready_q = 1'b0;
        busy      = 1'b1;
        beat      = '0;
      end
      if (r_hs) begin
        rvalid_q = 1'b0;
        beat     = beat + 1'b1;
        if (r_q.last) begin
          busy = 1'b0;  // Burst done
        end
      end
      if (axi_arvalid && !arready_q && !busy && !block_q) begin
        if (wait_cnt == ar_delay) begin
          arready_q = 1'b1;
          wait_cnt  = '0;
        end else begin
          wait_cnt = wait_cnt + 1'b1;
        end
      end
      // Random gaps between beats
      if (busy && !rvalid_q && (($urandom % 4) != 0)) begin
        r_q.id   = bad_id ? ~ar_q.id : ar_q.id;
        r_q.data = {ar_q.addr[ADDR_W-1:ADDR_LSB], {ADDR_LSB{1'b0}}} + 32'(beat);
        r_q.resp = (err_en && (beat == err_beat)) ? 2'b10 : 2'b00;  // SLVERR
        r_q.last = (beat == ar_q.len);
        rvalid_q = 1'b1;
      end
    end
  end

endmodule

// File: verif/axi_rd_master_tb.sv
`timescale 1ns/1ps

module axi_rd_master_tb;
  import axi_rd_pkg::*;

  localparam int N_ROWS    = 10;
  localparam int ACK_WAIT  = 10;
  localparam int IGN_WAIT  = 20;
  localparam int RUN_WAIT  = 3000;
  localparam int MASK_HOLD = 600;

  typedef enum logic [1:0] {
    SLV_NORMAL,
    SLV_BAD_ID,
    SLV_ERR_BEAT,
    SLV_NO_ARRDY
  } slv_mode_e;

  typedef struct packed {
    logic [2:0]        op;
    logic [LEN_W-1:0]  blen;
    logic [ADDR_W-1:0] addr;
    logic [2:0]        size;
    logic              mask;
    slv_mode_e         mode;
    rd_stage_e         stage;
    logic              id_err;
    logic              resp_err;
  } row_t;

  logic              aclk;
  logic              aresetn;
  logic              cmd_en;
  rd_cmd_t           cmd;
  logic              wdog_mask;
  logic              cmd_ack;
  axi_ar_t           axi_ar;
  logic              axi_arvalid;
  logic              axi_arready;
  axi_r_t            axi_r;
  logic              axi_rvalid;
  logic              axi_rready;
  logic              rddata_vld;
  logic [DATA_W-1:0] rddata_data;
  logic              rddata_cmptd;
  rd_sts_t           rddata_sts;
  logic              rddata_rdy;
  logic [3:0]        ar_delay;
  logic              ar_block;
  logic              bad_id;
  logic              err_en;
  logic [LEN_W-1:0]  err_beat;
  logic [ID_W-1:0]   id_model;
  int                ar_cnt = 0;

  // op, blen, addr, size, mask, slave mode, stage, id_err, resp_err
  row_t rows [N_ROWS] = '{
    '{3'b000, 8'd3,  32'h1000_0000, 3'd2, 1'b0, SLV_NORMAL,   STG_OK,      1'b0, 1'b0},
    '{3'b001, 8'd3,  32'h2000_0013, 3'd2, 1'b0, SLV_NORMAL,   STG_OK,      1'b0, 1'b0},
    '{3'b100, 8'd1,  32'h2000_0020, 3'd2, 1'b0, SLV_NORMAL,   STG_OK,      1'b0, 1'b0},
    '{3'b000, 8'd15, 32'h0000_4006, 3'd2, 1'b0, SLV_NORMAL,   STG_OK,      1'b0, 1'b0},
    '{3'b000, 8'd7,  32'h3000_0100, 3'd2, 1'b0, SLV_ERR_BEAT, STG_OK,      1'b0, 1'b1},
    '{3'b001, 8'd1,  32'h3000_0202, 3'd2, 1'b0, SLV_BAD_ID,   STG_OK,      1'b1, 1'b0},
    '{3'b000, 8'd0,  32'h4000_0004, 3'd2, 1'b0, SLV_NO_ARRDY, STG_ADDR_TO, 1'b0, 1'b0},
    '{3'b111, 8'd2,  32'h4000_0008, 3'd2, 1'b0, SLV_NORMAL,   STG_OK,      1'b0, 1'b0},
    '{3'b000, 8'd5,  32'h5000_0040, 3'd2, 1'b1, SLV_NO_ARRDY, STG_OK,      1'b0, 1'b0},
    '{3'b000, 8'd0,  32'h6000_0001, 3'd1, 1'b0, SLV_NORMAL,   STG_OK,      1'b0, 1'b0}
  };

  axi_rd_master i_dut (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .cmd_en       (cmd_en),
    .cmd          (cmd),
    .wdog_mask    (wdog_mask),
    .cmd_ack      (cmd_ack),
    .axi_ar       (axi_ar),
    .axi_arvalid  (axi_arvalid),
    .axi_arready  (axi_arready),
    .axi_r        (axi_r),
    .axi_rvalid   (axi_rvalid),
    .axi_rready   (axi_rready),
    .rddata_vld   (rddata_vld),
    .rddata_data  (rddata_data),
    .rddata_cmptd (rddata_cmptd),
    .rddata_sts   (rddata_sts),
    .rddata_rdy   (rddata_rdy)
  );

  axi_rd_slave_model i_slave (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .axi_ar      (axi_ar),
    .axi_arvalid (axi_arvalid),
    .axi_arready (axi_arready),
    .axi_r       (axi_r),
    .axi_rvalid  (axi_rvalid),
    .axi_rready  (axi_rready),
    .ar_delay    (ar_delay),
    .ar_block    (ar_block),
    .bad_id      (bad_id),
    .err_en      (err_en),
    .err_beat    (err_beat)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    if (aresetn && axi_arvalid && axi_arready) begin
      ar_cnt <= ar_cnt + 1;  // AR handshakes seen
    end
  end

  // **************************************************
  // Check helpers
  // **************************************************

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  function automatic rd_cmd_t make_cmd(input row_t row);
    return '{op: rd_op_e'(row.op), blen: row.blen, addr: row.addr, size: row.size};
  endfunction

  // Write and reserved opcodes must stay unanswered
  task automatic run_ignored(input row_t row);
    @(negedge aclk);
    cmd_en = 1'b1;
    cmd    = make_cmd(row);
    for (int i = 0; i < IGN_WAIT; i++) begin
      #1;
      assert (!cmd_ack && !axi_arvalid) else abort_run("ignored opcode got an ack or an AR");
      @(negedge aclk);
    end
    cmd_en = 1'b0;
  endtask

  task automatic run_read(input row_t row);
    logic [31:0] base;
    logic [31:0] exp_cnt;
    logic        aborts;
    logic        done;
    int          words;
    int          cyc;
    int          ar_start;
    base     = row.addr & 32'hFFFF_FFFC;
    aborts   = (row.mode == SLV_NO_ARRDY) && !row.mask;
    exp_cnt  = aborts ? 32'd0 : 32'(row.blen) + 32'd1;
    done     = 1'b0;
    words    = 0;
    ar_start = ar_cnt;
    @(negedge aclk);
    wdog_mask = row.mask;
    ar_block  = (row.mode == SLV_NO_ARRDY);
    bad_id    = (row.mode == SLV_BAD_ID);
    err_en    = (row.mode == SLV_ERR_BEAT);
    err_beat  = row.blen >> 1;
    ar_delay  = 4'($urandom % 4);
    cmd_en    = 1'b1;
    cmd       = make_cmd(row);
    cyc       = 0;
    #1;
    while (!cmd_ack) begin
      cyc++;
      assert (cyc < ACK_WAIT) else abort_run("timeout waiting for the command acknowledge");
      @(negedge aclk);
      #1;
    end
    @(negedge aclk);
    cmd_en = 1'b0;
    #1;
    assert (axi_arvalid) else abort_run("axi_arvalid did not rise after the acknowledge");
    check_val("axi_ar.addr", axi_ar.addr, base);
    check_val("axi_ar.len", 32'(axi_ar.len), 32'(row.blen));
    check_val("axi_ar.size", 32'(axi_ar.size), 32'(row.size));
    check_val("axi_ar.burst", 32'(axi_ar.burst), (row.op == 3'b001) ? 32'd2 : 32'd1);
    check_val("axi_ar.id", 32'(axi_ar.id), 32'(id_model));
    cyc = 0;
    while (!done) begin
      cyc++;
      assert (cyc < RUN_WAIT) else abort_run("timeout waiting for the end of the burst");
      @(negedge aclk);
      rddata_rdy = (($urandom % 4) != 0);
      if (row.mask && ar_block && (cyc >= MASK_HOLD)) begin
        ar_block = 1'b0;  // Let the stalled AR through
      end
      #1;
      if (row.mask && ar_block) begin
        assert (!rddata_vld) else abort_run("word returned while the watchdog was masked");
      end
      if (rddata_vld && rddata_rdy) begin
        if (aborts) begin
          check_val("rddata_data", rddata_data, 32'd0);
          check_val("rddata_cmptd", 32'(rddata_cmptd), 32'd1);
        end else begin
          check_val("rddata_data", rddata_data, base + 32'(words));
          check_val("rddata_cmptd", 32'(rddata_cmptd), (words == int'(row.blen)) ? 32'd1 : 32'd0);
        end
        words++;
        done = rddata_cmptd;
      end
    end
    check_val("rddata_sts.beat_cnt", 32'(rddata_sts.beat_cnt), exp_cnt);
    check_val("rddata_sts.stage", 32'(rddata_sts.stage), 32'(row.stage));
    check_val("rddata_sts.id_err", 32'(rddata_sts.id_err), 32'(row.id_err));
    check_val("rddata_sts.resp_err", 32'(rddata_sts.resp_err), 32'(row.resp_err));
    check_val("AR handshake count", 32'(ar_cnt - ar_start), aborts ? 32'd0 : 32'd1);
    @(negedge aclk);
    rddata_rdy = 1'b0;
    ar_block   = 1'b0;
    if (!aborts) begin
      id_model = id_model + 1'b1;  // Aborted IDs are reused
    end
  endtask

  // **************************************************
  // Main sequence
  // **************************************************

  initial begin
    aresetn    = 1'b0;
    cmd_en     = 1'b0;
    cmd        = '0;
    wdog_mask  = 1'b0;
    rddata_rdy = 1'b0;
    ar_delay   = '0;
    ar_block   = 1'b0;
    bad_id     = 1'b0;
    err_en     = 1'b0;
    err_beat   = '0;
    id_model   = '0;
    void'($urandom(41143));
    repeat (4) @(posedge aclk);
    @(negedge aclk);
    assert (!cmd_ack && !axi_arvalid && !axi_rready && !rddata_vld && !rddata_cmptd)
      else abort_run("outputs not low during reset");
    aresetn = 1'b1;
    for (int i = 0; i < N_ROWS; i++) begin
      if ((rows[i].op == 3'b000) || (rows[i].op == 3'b001)) begin
        run_read(rows[i]);
      end else begin
        run_ignored(rows[i]);
      end
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: axi_rd_master.f
source/axi_rd_pkg.sv
source/axi_rd_fsm.sv
source/axi_rd_wdog.sv
source/axi_rd_cmd.sv
source/axi_rd_data.sv
source/axi_rd_master.sv
verif/axi_rd_slave_model.sv
verif/axi_rd_master_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the AXI read master testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f axi_rd_master.f --top-module axi_rd_master_tb \
  -Mdir obj_dir -o axi_rd_master_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/axi_rd_master_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi
exit 0
